// File: verilog/lc3_pkg.sv
// LC-3 subset core shared definitions
// Word types, opcode, ALU and state encodings, instruction field positions
`default_nettype none

package lc3_pkg;

	localparam int word_w   = 16;
	localparam int reg_aw   = 3;
	localparam int num_regs = 8;

	typedef logic [word_w-1:0] word_t;
	typedef logic [reg_aw-1:0] reg_addr_t;

	// Codes not listed here run as no-ops
	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ld   = 4'b0010,
		op_st   = 4'b0011,
		op_and  = 4'b0101,
		op_not  = 4'b1001,
		op_jmp  = 4'b1100,
		op_halt = 4'b1111
	} opcode_t;

	typedef enum logic [1:0] {
		alu_add    = 2'd0,
		alu_and    = 2'd1,
		alu_not    = 2'd2,
		alu_pass_a = 2'd3
	} alu_op_t;

	typedef enum logic [1:0] {
		st_fetch  = 2'd0,
		st_decode = 2'd1,
		st_exec   = 2'd2,
		st_halt   = 2'd3
	} state_t;

	// ==============================
	// IR field positions
	localparam int op_hi    = 15;
	localparam int op_lo    = 12;
	localparam int dr_hi    = 11;
	localparam int dr_lo    = 9;
	localparam int sr1_hi   = 8;
	localparam int sr1_lo   = 6;
	localparam int imm_bit  = 5;
	localparam int sr2_hi   = 2;
	localparam int sr2_lo   = 0;
	localparam int nzp_hi   = 11;
	localparam int nzp_lo   = 9;
	// Sign bit of each offset field
	localparam int imm5_hi  = 4;
	localparam int off9_hi  = 8;

endpackage

`default_nettype wire

// File: verilog/lc3_control.sv
// LC-3 instruction sequencer
// Fetch, decode, execute FSM that drives all datapath and register file controls
`timescale 1ns/1ps
`default_nettype none

module lc3_control (
	input  logic               clk,
	input  logic               rst,
	input  lc3_pkg::word_t     ir,
	input  logic               n,
	input  logic               z,
	input  logic               p,
	output logic               ir_ld,
	output logic               pc_inc,
	output logic               pc_ld,
	output logic               pc_ld_off,
	output lc3_pkg::alu_op_t   alu_op,
	output logic               use_imm,
	output logic               wb_mem,
	output logic               rf_we,
	output lc3_pkg::reg_addr_t rf_waddr,
	output lc3_pkg::reg_addr_t rf_raddr0,
	output lc3_pkg::reg_addr_t rf_raddr1,
	output logic               cc_ld,
	output logic               addr_data,
	output logic               mem_we,
	output logic               halted
);

	lc3_pkg::state_t  state;
	lc3_pkg::state_t  next_state;
	lc3_pkg::opcode_t op;
	logic [2:0]       nzp_mask;
	logic             br_take;

	assign op       = lc3_pkg::opcode_t'(ir[lc3_pkg::op_hi:lc3_pkg::op_lo]);
	assign nzp_mask = ir[lc3_pkg::nzp_hi:lc3_pkg::nzp_lo];

	// Empty mask behaves as unconditional
	assign br_take = ((nzp_mask & {n, z, p}) != 3'b000) || (nzp_mask == 3'b000);

	// ST reads its source from the DR field
	assign rf_raddr0 = (op == lc3_pkg::op_st) ? ir[lc3_pkg::dr_hi:lc3_pkg::dr_lo]
	                                          : ir[lc3_pkg::sr1_hi:lc3_pkg::sr1_lo];
	assign rf_raddr1 = ir[lc3_pkg::sr2_hi:lc3_pkg::sr2_lo];
	assign rf_waddr  = ir[lc3_pkg::dr_hi:lc3_pkg::dr_lo];
	assign halted    = (state == lc3_pkg::st_halt);

	// ==============================
	// State register
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= lc3_pkg::st_fetch;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			lc3_pkg::st_fetch:  next_state = lc3_pkg::st_decode;
			lc3_pkg::st_decode: begin
				if (op == lc3_pkg::op_halt) begin
					next_state = lc3_pkg::st_halt;
				end else begin
					next_state = lc3_pkg::st_exec;
				end
			end
			lc3_pkg::st_exec:   next_state = lc3_pkg::st_fetch;
			default:            next_state = lc3_pkg::st_halt;
		endcase
	end

	// ==============================
	// Control outputs
	always_comb begin
		ir_ld     = 1'b0;
		pc_inc    = 1'b0;
		pc_ld     = 1'b0;
		pc_ld_off = 1'b0;
		alu_op    = lc3_pkg::alu_add;
		use_imm   = 1'b0;
		wb_mem    = 1'b0;
		rf_we     = 1'b0;
		cc_ld     = 1'b0;
		addr_data = 1'b0;
		mem_we    = 1'b0;
		case (state)
			lc3_pkg::st_fetch: begin
				ir_ld  = 1'b1;
				pc_inc = 1'b1;
			end
			lc3_pkg::st_exec: begin
				case (op)
					lc3_pkg::op_add, lc3_pkg::op_and: begin
						alu_op  = (op == lc3_pkg::op_add) ? lc3_pkg::alu_add
						                                  : lc3_pkg::alu_and;
						use_imm = ir[lc3_pkg::imm_bit];
						rf_we   = 1'b1;
						cc_ld   = 1'b1;
					end
					lc3_pkg::op_not: begin
						alu_op = lc3_pkg::alu_not;
						rf_we  = 1'b1;
						cc_ld  = 1'b1;
					end
					lc3_pkg::op_ld: begin
						addr_data = 1'b1;
						wb_mem    = 1'b1;
						rf_we     = 1'b1;
						cc_ld     = 1'b1;
					end
					lc3_pkg::op_st: begin
						alu_op    = lc3_pkg::alu_pass_a;
						addr_data = 1'b1;
						mem_we    = 1'b1;
					end
					lc3_pkg::op_br: pc_ld_off = br_take;
					lc3_pkg::op_jmp: begin
						alu_op = lc3_pkg::alu_pass_a;
						pc_ld  = 1'b1;
					end
					default: ;
				endcase
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/lc3_regfile.sv
// General register file, eight words
// Synchronous write, two combinational read ports
`timescale 1ns/1ps
`default_nettype none

module lc3_regfile (
	input  logic               clk,
	input  logic               we,
	input  lc3_pkg::reg_addr_t waddr,
	input  lc3_pkg::word_t     wdata,
	input  lc3_pkg::reg_addr_t raddr0,
	input  lc3_pkg::reg_addr_t raddr1,
	output lc3_pkg::word_t     rdata0,
	output lc3_pkg::word_t     rdata1
);

	lc3_pkg::word_t regs [lc3_pkg::num_regs];

	always_ff @(posedge clk) begin
		if (we) begin
			regs[waddr] <= wdata;
		end
	end

	// Reads see the old value during a write
	assign rdata0 = regs[raddr0];
	assign rdata1 = regs[raddr1];

endmodule

`default_nettype wire

// File: verilog/lc3_datapath.sv
// LC-3 datapath
// PC, IR, ALU, offset extension, write-back select, flags and memory address mux
`timescale 1ns/1ps
`default_nettype none

module lc3_datapath (
	input  logic             clk,
	input  logic             rst,
	input  logic             ir_ld,
	input  logic             pc_inc,
	input  logic             pc_ld,
	input  logic             pc_ld_off,
	input  lc3_pkg::alu_op_t alu_op,
	input  logic             use_imm,
	input  logic             wb_mem,
	input  logic             cc_ld,
	input  logic             addr_data,
	input  lc3_pkg::word_t   rdata0,
	input  lc3_pkg::word_t   rdata1,
	input  lc3_pkg::word_t   mem_rdata,
	output lc3_pkg::word_t   ir,
	output logic             n,
	output logic             z,
	output logic             p,
	output lc3_pkg::word_t   wdata,
	output lc3_pkg::word_t   mem_addr,
	output lc3_pkg::word_t   mem_wdata
);

	localparam int imm5_ext = lc3_pkg::word_w - lc3_pkg::imm5_hi - 1;
	localparam int off9_ext = lc3_pkg::word_w - lc3_pkg::off9_hi - 1;

	lc3_pkg::word_t pc;
	lc3_pkg::word_t imm5;
	lc3_pkg::word_t off9;
	lc3_pkg::word_t pc_off;
	lc3_pkg::word_t alu_b;
	lc3_pkg::word_t alu_y;

	// ==============================
	// Offset extension
	assign imm5 = {{imm5_ext{ir[lc3_pkg::imm5_hi]}}, ir[lc3_pkg::imm5_hi:0]};
	assign off9 = {{off9_ext{ir[lc3_pkg::off9_hi]}}, ir[lc3_pkg::off9_hi:0]};

	// PC already points past the instruction here
	assign pc_off = pc + off9;

	// ==============================
	// PC and IR
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
		end else if (pc_ld) begin
			pc <= alu_y;
		end else if (pc_ld_off) begin
			pc <= pc_off;
		end else if (pc_inc) begin
			pc <= pc + lc3_pkg::word_t'(1);
		end
	end

	always_ff @(posedge clk) begin
		if (ir_ld) begin
			ir <= mem_rdata;
		end
	end

	// ==============================
	// ALU
	assign alu_b = use_imm ? imm5 : rdata1;

	always_comb begin
		case (alu_op)
			lc3_pkg::alu_add: alu_y = rdata0 + alu_b;
			lc3_pkg::alu_and: alu_y = rdata0 & alu_b;
			lc3_pkg::alu_not: alu_y = ~rdata0;
			default:          alu_y = rdata0;
		endcase
	end

	assign wdata = wb_mem ? mem_rdata : alu_y;

	// Flags follow the value being written back
	always_ff @(posedge clk) begin
		if (rst) begin
			n <= 1'b0;
			z <= 1'b0;
			p <= 1'b0;
		end else if (cc_ld) begin
			n <= wdata[lc3_pkg::word_w-1];
			z <= (wdata == '0);
			p <= !wdata[lc3_pkg::word_w-1] && (wdata != '0);
		end
	end

	// ==============================
	// Memory port
	assign mem_addr  = addr_data ? pc_off : pc;
	assign mem_wdata = alu_y;

endmodule

`default_nettype wire

// File: verilog/lc3_core.sv
// LC-3 subset core top level
// Controller, datapath and register file around one memory port
`timescale 1ns/1ps
`default_nettype none

module lc3_core (
	input  logic           clk,
	input  logic           rst,
	input  lc3_pkg::word_t mem_rdata,
	output lc3_pkg::word_t mem_addr,
	output lc3_pkg::word_t mem_wdata,
	output logic           mem_we,
	output logic           halted
);

	lc3_pkg::word_t     ir;
	lc3_pkg::word_t     wdata;
	lc3_pkg::word_t     rdata0;
	lc3_pkg::word_t     rdata1;
	lc3_pkg::alu_op_t   alu_op;
	lc3_pkg::reg_addr_t rf_waddr;
	lc3_pkg::reg_addr_t rf_raddr0;
	lc3_pkg::reg_addr_t rf_raddr1;
	logic               n;
	logic               z;
	logic               p;
	logic               ir_ld;
	logic               pc_inc;
	logic               pc_ld;
	logic               pc_ld_off;
	logic               use_imm;
	logic               wb_mem;
	logic               rf_we;
	logic               cc_ld;
	logic               addr_data;

	lc3_control ctrl0 (
		.clk(clk), .rst(rst), .ir(ir), .n(n), .z(z), .p(p),
		.ir_ld(ir_ld), .pc_inc(pc_inc), .pc_ld(pc_ld), .pc_ld_off(pc_ld_off),
		.alu_op(alu_op), .use_imm(use_imm), .wb_mem(wb_mem), .rf_we(rf_we),
		.rf_waddr(rf_waddr), .rf_raddr0(rf_raddr0), .rf_raddr1(rf_raddr1),
		.cc_ld(cc_ld), .addr_data(addr_data), .mem_we(mem_we), .halted(halted)
	);

	lc3_datapath dp0 (
		.clk(clk), .rst(rst), .ir_ld(ir_ld), .pc_inc(pc_inc), .pc_ld(pc_ld),
		.pc_ld_off(pc_ld_off), .alu_op(alu_op), .use_imm(use_imm), .wb_mem(wb_mem),
		.cc_ld(cc_ld), .addr_data(addr_data), .rdata0(rdata0), .rdata1(rdata1),
		.mem_rdata(mem_rdata), .ir(ir), .n(n), .z(z), .p(p), .wdata(wdata),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata)
	);

	lc3_regfile rf0 (
		.clk(clk), .we(rf_we), .waddr(rf_waddr), .wdata(wdata),
		.raddr0(rf_raddr0), .raddr1(rf_raddr1), .rdata0(rdata0), .rdata1(rdata1)
	);

endmodule

`default_nettype wire

// File: dv/lc3_prog.svh
// LC-3 test program image and expected store sequence
// Operands are drawn from the seeded generator, results follow the ISA rules
`ifndef LC3_PROG_SVH
`define LC3_PROG_SVH

localparam int             n_stores  = 8;
localparam lc3_pkg::word_t halt_addr = 16'h0034;

// Each entry is {store address, store data}
logic [31:0] exp_store [n_stores];

task automatic load_program();
	lc3_pkg::word_t a;
	lc3_pkg::word_t b;
	a = lc3_pkg::word_t'($random(seed));
	b = lc3_pkg::word_t'($random(seed));
	// Reserved opcode 1101 everywhere else, so stray fetches are no-ops
	for (int i = 0; i < 256; i++) begin
		mem[i] = {8'hd0, i[7:0]};
	end
	mem['h00] = enc_pc(lc3_pkg::op_ld, 1, 'h00, 'h40);
	mem['h01] = enc_pc(lc3_pkg::op_ld, 2, 'h01, 'h41);
	mem['h02] = enc_rr(lc3_pkg::op_add, 3, 1, 2);
	mem['h03] = enc_pc(lc3_pkg::op_st, 3, 'h03, 'h60);
	mem['h04] = enc_rr(lc3_pkg::op_and, 3, 1, 2);
	mem['h05] = enc_pc(lc3_pkg::op_st, 3, 'h05, 'h61);
	mem['h06] = enc_ri(lc3_pkg::op_add, 3, 1, -5);
	mem['h07] = enc_pc(lc3_pkg::op_st, 3, 'h07, 'h62);
	mem['h08] = enc_ri(lc3_pkg::op_and, 3, 1, -6);
	mem['h09] = enc_pc(lc3_pkg::op_st, 3, 'h09, 'h63);
	mem['h0a] = enc_ri(lc3_pkg::op_not, 3, 1, -1);
	mem['h0b] = enc_pc(lc3_pkg::op_st, 3, 'h0b, 'h64);
	mem['h0c] = enc_pc(lc3_pkg::op_ld, 4, 'h0c, 'h42);
	mem['h0d] = enc_pc(lc3_pkg::op_st, 4, 'h0d, 'h65);
	// Zero load sets z, then BRz skips a marker and BRnp falls through
	mem['h0e] = enc_pc(lc3_pkg::op_ld, 5, 'h0e, 'h43);
	mem['h0f] = enc_pc(lc3_pkg::op_br, 2, 'h0f, 'h11);
	mem['h10] = enc_pc(lc3_pkg::op_st, 4, 'h10, 'h6e);
	mem['h11] = enc_pc(lc3_pkg::op_br, 5, 'h11, 'h13);
	mem['h12] = enc_pc(lc3_pkg::op_st, 4, 'h12, 'h66);
	mem['h13] = enc_pc(lc3_pkg::op_ld, 6, 'h13, 'h46);
	mem['h14] = enc_rr(lc3_pkg::op_jmp, 0, 6, 0);
	mem['h15] = enc_pc(lc3_pkg::op_st, 4, 'h15, 'h6f);
	// Jump target code, backward load and BRn over a marker
	mem['h30] = enc_pc(lc3_pkg::op_ld, 7, 'h30, 'h28);
	mem['h31] = enc_pc(lc3_pkg::op_st, 7, 'h31, 'h67);
	mem['h32] = enc_pc(lc3_pkg::op_br, 4, 'h32, 'h34);
	mem['h33] = enc_pc(lc3_pkg::op_st, 4, 'h33, 'h6e);
	mem['h34] = {lc3_pkg::op_halt, 12'h025};
	mem['h28] = 16'h8421;
	mem['h40] = a;
	mem['h41] = b;
	mem['h42] = 16'h1234;
	mem['h43] = 16'h0000;
	mem['h46] = 16'h0030;
	exp_store[0] = {16'h0060, a + b};
	exp_store[1] = {16'h0061, a & b};
	// imm5 of -5 and -6 after sign extension
	exp_store[2] = {16'h0062, a + 16'hfffb};
	exp_store[3] = {16'h0063, a & 16'hfffa};
	exp_store[4] = {16'h0064, ~a};
	exp_store[5] = {16'h0065, 16'h1234};
	exp_store[6] = {16'h0066, 16'h1234};
	exp_store[7] = {16'h0067, 16'h8421};
endtask

`endif

// File: dv/tb_lc3.sv
// Testbench for the LC-3 subset core
// Memory model, program run, store and halt checks with a watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_lc3;

	localparam int clk_period  = 100;
	localparam int prog_instrs = 24;

	logic           clk = 1'b0;
	logic           rst = 1'b1;
	lc3_pkg::word_t mem_rdata;
	lc3_pkg::word_t mem_addr;
	lc3_pkg::word_t mem_wdata;
	logic           mem_we;
	logic           halted;

	lc3_pkg::word_t mem [256];
	integer         seed = 32'h9fe4;
	int             cycle = 0;
	int             store_idx = 0;
	int             halt_fetch = -1;
	logic           halt_seen = 1'b0;
	int             n_pass = 0;
	int             n_fail = 0;

	// ==============================
	// Instruction encoders
	function automatic lc3_pkg::word_t enc_rr(lc3_pkg::opcode_t op, int dr, int sr1,
			int sr2);
		return {op, dr[2:0], sr1[2:0], 3'b000, sr2[2:0]};
	endfunction

	function automatic lc3_pkg::word_t enc_ri(lc3_pkg::opcode_t op, int dr, int sr1,
			int imm);
		return {op, dr[2:0], sr1[2:0], 1'b1, imm[4:0]};
	endfunction

	// Offset counts from the word after the instruction
	function automatic lc3_pkg::word_t enc_pc(lc3_pkg::opcode_t op, int r, int at,
			int target);
		int off;
		off = target - (at + 1);
		return {op, r[2:0], off[8:0]};
	endfunction

	`include "lc3_prog.svh"

	lc3_core dut0 (
		.clk(clk), .rst(rst), .mem_rdata(mem_rdata), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_we(mem_we), .halted(halted)
	);

	always #(clk_period / 2) clk = ~clk;

	always @(posedge clk) cycle <= cycle + 1;

	// ==============================
	// Memory model
	assign mem_rdata = mem[mem_addr[7:0]];

	always @(posedge clk) begin
		if (mem_we) begin
			mem[mem_addr[7:0]] <= mem_wdata;
		end
	end

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (expected == actual) begin
			$display("%s passed", name);
			n_pass++;
		end else begin
			$display("FAILED %s expected 'h%0h actual 'h%0h", name, expected, actual);
			n_fail++;
		end
	endtask

	// Outputs are settled at the falling edge
	always @(negedge clk) begin
		if (!rst) begin
			if (halt_fetch < 0 && mem_addr == halt_addr) begin
				halt_fetch = cycle;
			end
			if (mem_we && (halted || store_idx >= n_stores)) begin
				$display("Store to address %h after the last expected store", mem_addr);
				n_fail++;
			end else if (mem_we) begin
				check_value($sformatf("store_%0d", store_idx), exp_store[store_idx],
					{mem_addr, mem_wdata});
				store_idx++;
			end
			if (halted && !halt_seen) begin
				halt_seen = 1'b1;
				// Fetch, decode, then parked
				check_value("halt_timing", halt_fetch + 2, cycle);
				check_value("store_count", n_stores, store_idx);
			end else if (halt_seen && !halted) begin
				$display("The halted output went low again after the core stopped");
				n_fail++;
			end
		end
	end

	// ==============================
	// Main sequence
	initial begin
		load_program();
		repeat (3) @(posedge clk);
		#1 rst = 1'b0;
		wait (halted);
		repeat (4) @(posedge clk);
		$display("Checks passed: %0d  failed: %0d", n_pass, n_fail);
		if (n_fail == 0 && n_pass == n_stores + 2) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	// Three cycles per instruction plus reset and slack
	initial begin
		#((prog_instrs * 3 + 3 + 20) * clk_period);
		$display("Timeout: the core did not reach HALT within the cycle budget");
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
+incdir+dv
verilog/lc3_pkg.sv
verilog/lc3_control.sv
verilog/lc3_regfile.sv
verilog/lc3_datapath.sv
verilog/lc3_core.sv
dv/tb_lc3.sv

// File: run.sh
#!/bin/sh
# Build and run the LC-3 core simulation with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_lc3 -f src.f -o sim_lc3
out=$(./obj_dir/sim_lc3)
echo "$out"
if echo "$out" | grep -qx "RESULT: PASS"; then
	exit 0
fi
exit 1
